// ==== rtl/sdcard_proto_pkg.sv ====
// ####################
// SD command-layer definitions only, no data bus or CRC fields
// Delays are counted in clock cycles of the card model
// ####################

package sdcard_proto_pkg;

    // Command indices handled by the card model
    typedef enum logic [5:0] {
        CMD_GO_IDLE         = 6'd0,
        CMD_ALL_SEND_CID    = 6'd2,
        CMD_SEND_RCA        = 6'd3,
        CMD_IF_COND         = 6'd8,
        CMD_VOLT_SWITCH     = 6'd11,
        CMD_SD_SEND_OP_COND = 6'd41,
        CMD_APP_CMD         = 6'd55
    } sdcard_cmd_e;

    // Which response word the builder forms
    typedef enum logic [2:0] {
        RESP_NONE,
        RESP_ZERO,
        RESP_IF_COND,
        RESP_OCR,
        RESP_CID,
        RESP_RCA,
        RESP_ILLEGAL
    } sdcard_resp_kind_e;

    // Response delays
    localparam int SD_DLY_LONG  = 20;
    localparam int SD_DLY_SHORT = 2;
    localparam int SD_DLY_MIN   = 1;

    // Field positions inside the 32-bit response word
    localparam int SD_OCR_BUSY_BIT = 31;
    localparam int SD_RCA_LSB      = 16;
    localparam logic [31:0] SD_RESP_ILLEGAL = 32'hffff_ffff;

endpackage

// ==== rtl/sdcard_model_pkg.sv ====
// ####################
// Card states and internal request/response structs
// Transfer states are not modelled
// ####################

package sdcard_model_pkg;

    // Identification-mode states plus standby and inactive
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READY,
        ST_IDENT,
        ST_STBY,
        ST_INA
    } sdcard_state_e;

    // Host request as taken on the valid/ready handshake
    typedef struct packed {
        sdcard_proto_pkg::sdcard_cmd_e cmd;
        logic [31:0]                   arg;
    } sdcard_req_t;

    // Order from the FSM to the response builder
    typedef struct packed {
        sdcard_proto_pkg::sdcard_resp_kind_e kind;
        logic [31:0]                         arg;
    } sdcard_resp_t;

endpackage

// ==== rtl/sdcard_timers.sv ====
// ####################
// Power-up counter saturates at POWERUP_DELAY
// ####################

`timescale 1ns/1ps

module sdcard_timers #(
    parameter int POWERUP_DELAY = 700
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_dly_load,
    input  logic [31:0] i_dly_value,
    output logic        o_dly_done,
    output logic        o_powerup_done
);

    logic [31:0] pwr_cnt;
    logic [31:0] dly_cnt;
    logic        pwr_done;

    assign pwr_done = (pwr_cnt >= POWERUP_DELAY);

    // Emulates the card releasing the ACMD41 busy bit
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            pwr_cnt <= '0;
        end else if (!pwr_done) begin
            pwr_cnt <= pwr_cnt + 32'd1;
        end
    end

    // Response delay, counts down to zero and stops
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            dly_cnt <= '0;
        end else if (i_dly_load) begin
            dly_cnt <= i_dly_value;
        end else if (dly_cnt != '0) begin
            dly_cnt <= dly_cnt - 32'd1;
        end
    end

    assign o_dly_done     = (dly_cnt == '0);
    assign o_powerup_done = pwr_done;

endmodule

// ==== rtl/sdcard_resp_builder.sv ====
// ####################
// OCR busy bit is sampled when the command is accepted
// ####################

`timescale 1ns/1ps

module sdcard_resp_builder #(
    parameter logic [3:0]  VHS        = 4'h1,
    parameter logic        PCIE_1_2V  = 1'b0,
    parameter logic        PCIE_AVAIL = 1'b0,
    parameter logic [23:0] VDD_WINDOW = 24'hff8000,
    parameter logic [31:0] CID_WORD   = 32'h0000_0000,
    parameter logic [15:0] RCA        = 16'h0000
) (
    input  logic                         i_clk,
    input  logic                         i_nrst,
    input  logic                         i_start,
    input  sdcard_model_pkg::sdcard_resp_t i_resp,
    input  logic                         i_powerup_done,
    input  logic                         i_release,
    output logic                         o_taken,
    output logic                         o_resp_valid,
    output logic [31:0]                  o_resp_data,
    input  logic                         i_resp_ready
);

    import sdcard_proto_pkg::*;

    logic [31:0] word_nxt;
    logic [31:0] r_data;
    logic        r_valid;

    always_comb begin
        word_nxt = '0;
        case (i_resp.kind)
            RESP_IF_COND: begin
                word_nxt[13]   = i_resp.arg[13] & PCIE_1_2V;
                word_nxt[12]   = i_resp.arg[12] & PCIE_AVAIL;
                word_nxt[11:8] = i_resp.arg[11:8] & VHS;
                // Check pattern goes back unchanged
                word_nxt[7:0]  = i_resp.arg[7:0];
            end
            RESP_OCR: begin
                word_nxt[SD_OCR_BUSY_BIT] = i_powerup_done;
                word_nxt[23:0]            = i_resp.arg[23:0] & VDD_WINDOW;
            end
            RESP_CID:     word_nxt = CID_WORD;
            RESP_RCA:     word_nxt[SD_RCA_LSB +: 16] = RCA;
            RESP_ILLEGAL: word_nxt = SD_RESP_ILLEGAL;
            default:      word_nxt = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            r_data <= word_nxt;
        end
    end

    // Valid held until the host takes the word
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_valid <= 1'b0;
        end else if (i_release) begin
            r_valid <= 1'b1;
        end else if (r_valid && i_resp_ready) begin
            r_valid <= 1'b0;
        end
    end

    assign o_taken      = r_valid & i_resp_ready;
    assign o_resp_valid = r_valid;
    assign o_resp_data  = r_data;

endmodule

// ==== rtl/sdcard_cmd_fsm.sv ====
// ####################
// One command in flight; CMD55 only accepted in idle
// Inactive state is left by reset only
// ####################

`timescale 1ns/1ps

module sdcard_cmd_fsm #(
    parameter logic [23:0] VDD_WINDOW = 24'hff8000
) (
    input  logic                         i_clk,
    input  logic                         i_nrst,
    input  logic                         i_req_valid,
    input  sdcard_model_pkg::sdcard_req_t  i_req,
    output logic                         o_req_ready,
    input  logic                         i_powerup_done,
    input  logic                         i_dly_done,
    output logic                         o_dly_load,
    output logic [31:0]                  o_dly_value,
    output logic                         o_bld_start,
    output sdcard_model_pkg::sdcard_resp_t o_bld_resp,
    output logic                         o_bld_release,
    input  logic                         i_bld_taken
);

    import sdcard_proto_pkg::*;
    import sdcard_model_pkg::*;

    typedef enum logic [1:0] {
        WAIT_REQ,
        WAIT_DLY,
        WAIT_TAKE
    } ctl_e;

    ctl_e              ctl;
    sdcard_state_e     state;
    sdcard_state_e     state_nxt;
    logic              app_flag;
    logic              app_nxt;
    logic              r_req_ready;
    logic              r_release;
    logic              req_fire;
    sdcard_resp_kind_e dec_kind;
    logic [31:0]       dec_dly;
    logic [23:0]       masked_ocr;

    assign req_fire   = i_req_valid & r_req_ready;
    assign masked_ocr = i_req.arg[23:0] & VDD_WINDOW;

    // Per-state command decode
    always_comb begin
        dec_kind  = RESP_ILLEGAL;
        dec_dly   = '0;
        state_nxt = state;
        app_nxt   = 1'b0;
        if ((state != ST_INA) && (i_req.cmd == CMD_GO_IDLE)) begin
            dec_kind  = RESP_ZERO;
            dec_dly   = (state == ST_IDLE) ? SD_DLY_LONG : SD_DLY_SHORT;
            state_nxt = ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    case (i_req.cmd)
                        CMD_IF_COND: begin
                            dec_kind = RESP_IF_COND;
                            dec_dly  = SD_DLY_LONG;
                        end
                        CMD_APP_CMD: begin
                            dec_kind = RESP_NONE;
                            app_nxt  = 1'b1;
                        end
                        CMD_SD_SEND_OP_COND: begin
                            // Without the CMD55 prefix this stays illegal
                            if (app_flag) begin
                                dec_kind = RESP_OCR;
                                dec_dly  = SD_DLY_LONG;
                                if (masked_ocr == '0) begin
                                    state_nxt = ST_INA;
                                end else if (i_powerup_done) begin
                                    state_nxt = ST_READY;
                                end
                            end
                        end
                        default: ;
                    endcase
                end
                ST_READY: begin
                    if (i_req.cmd == CMD_ALL_SEND_CID) begin
                        dec_kind  = RESP_CID;
                        dec_dly   = SD_DLY_MIN;
                        state_nxt = ST_IDENT;
                    end else if (i_req.cmd == CMD_VOLT_SWITCH) begin
                        dec_kind = RESP_ZERO;
                        dec_dly  = SD_DLY_MIN;
                    end
                end
                ST_IDENT: begin
                    if (i_req.cmd == CMD_SEND_RCA) begin
                        dec_kind  = RESP_RCA;
                        dec_dly   = SD_DLY_MIN;
                        state_nxt = ST_STBY;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            ctl         <= WAIT_REQ;
            state       <= ST_IDLE;
            app_flag    <= 1'b0;
            r_req_ready <= 1'b1;
            r_release   <= 1'b0;
        end else begin
            // Release is one cycle after the delay expires
            r_release <= (ctl == WAIT_DLY) && i_dly_done;
            case (ctl)
                WAIT_REQ: begin
                    if (req_fire) begin
                        r_req_ready <= 1'b0;
                        state       <= state_nxt;
                        app_flag    <= app_nxt;
                        if (dec_kind != RESP_NONE) begin
                            ctl <= WAIT_DLY;
                        end
                    end else begin
                        // CMD55 drops ready for a single cycle
                        r_req_ready <= 1'b1;
                    end
                end
                WAIT_DLY: begin
                    if (i_dly_done) begin
                        ctl <= WAIT_TAKE;
                    end
                end
                default: begin
                    if (i_bld_taken) begin
                        ctl         <= WAIT_REQ;
                        r_req_ready <= 1'b1;
                    end
                end
            endcase
        end
    end

    assign o_req_ready   = r_req_ready;
    assign o_dly_load    = req_fire && (dec_kind != RESP_NONE);
    assign o_dly_value   = dec_dly;
    assign o_bld_start   = req_fire && (dec_kind != RESP_NONE);
    assign o_bld_resp    = '{kind: dec_kind, arg: i_req.arg};
    assign o_bld_release = r_release;

endmodule

// ==== rtl/sdcard_card_top.sv ====
// ####################
// SD card command-layer model, no data lines
// Response latency is the command delay plus two cycles
// ####################

`timescale 1ns/1ps

module sdcard_card_top #(
    parameter int          POWERUP_DELAY = 700,
    parameter logic [3:0]  VHS           = 4'h1,
    parameter logic        PCIE_1_2V     = 1'b0,
    parameter logic        PCIE_AVAIL    = 1'b0,
    parameter logic [23:0] VDD_WINDOW    = 24'hff8000,
    parameter logic [31:0] CID_WORD      = 32'h0000_0000,
    parameter logic [15:0] RCA           = 16'h0000
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_req_valid,
    input  logic [5:0]  i_req_cmd,
    input  logic [31:0] i_req_arg,
    output logic        o_req_ready,
    output logic        o_resp_valid,
    output logic [31:0] o_resp_data,
    input  logic        i_resp_ready
);

    import sdcard_proto_pkg::*;
    import sdcard_model_pkg::*;

    sdcard_req_t  req;
    sdcard_resp_t bld_resp;
    logic         powerup_done;
    logic         dly_done;
    logic         dly_load;
    logic [31:0]  dly_value;
    logic         bld_start;
    logic         bld_release;
    logic         bld_taken;

    // Unknown indices pass through the cast and decode as illegal
    assign req = '{cmd: sdcard_cmd_e'(i_req_cmd), arg: i_req_arg};

    sdcard_cmd_fsm #(
        .VDD_WINDOW (VDD_WINDOW)
    ) u_fsm (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_req_valid    (i_req_valid),
        .i_req          (req),
        .o_req_ready    (o_req_ready),
        .i_powerup_done (powerup_done),
        .i_dly_done     (dly_done),
        .o_dly_load     (dly_load),
        .o_dly_value    (dly_value),
        .o_bld_start    (bld_start),
        .o_bld_resp     (bld_resp),
        .o_bld_release  (bld_release),
        .i_bld_taken    (bld_taken)
    );

    sdcard_timers #(
        .POWERUP_DELAY (POWERUP_DELAY)
    ) u_timers (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_dly_load     (dly_load),
        .i_dly_value    (dly_value),
        .o_dly_done     (dly_done),
        .o_powerup_done (powerup_done)
    );

    sdcard_resp_builder #(
        .VHS        (VHS),
        .PCIE_1_2V  (PCIE_1_2V),
        .PCIE_AVAIL (PCIE_AVAIL),
        .VDD_WINDOW (VDD_WINDOW),
        .CID_WORD   (CID_WORD),
        .RCA        (RCA)
    ) u_builder (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_start        (bld_start),
        .i_resp         (bld_resp),
        .i_powerup_done (powerup_done),
        .i_release      (bld_release),
        .o_taken        (bld_taken),
        .o_resp_valid   (o_resp_valid),
        .o_resp_data    (o_resp_data),
        .i_resp_ready   (i_resp_ready)
    );

endmodule

// ==== tests/tb_clk_gen.sv ====
// ####################
// Reset is released on a falling edge after RESET_CYCLES rising edges
// ####################

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_nrst
);

    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2.0) o_clk = ~o_clk;

    initial begin
        o_nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_nrst = 1'b1;
    end

endmodule

// ==== tests/tb_sdcard_card.sv ====
// ####################
// Checks response values and order only, not cycle counts
// Power-up entries rely on a margin around POWERUP_DELAY
// ####################

`timescale 1ns/1ps

module tb_sdcard_card;

    import sdcard_proto_pkg::*;

    localparam int          POWERUP_DELAY = 60;
    localparam logic [3:0]  VHS_P         = 4'h1;
    localparam logic        PCIE_1_2V_P   = 1'b0;
    localparam logic        PCIE_AVAIL_P  = 1'b0;
    localparam logic [23:0] VDD_WINDOW_P  = 24'hff8000;
    localparam logic [31:0] CID_WORD_P    = 32'h0353_4453;
    localparam logic [15:0] RCA_P         = 16'hb368;
    localparam logic [31:0] SEED          = 32'd3027;
    localparam int MAX_IDLE   = 3;
    localparam int MAX_STALL  = 3;
    localparam int PWR_MARGIN = 10;
    // Power-up phase of an entry
    localparam int PH_ANY   = 0;
    localparam int PH_EARLY = 1;
    localparam int PH_LATE  = 2;

    typedef struct packed {
        logic [5:0]  cmd;
        logic [31:0] arg;
        int          idle;
        bit          has_resp;
        logic [31:0] exp;
        int          phase;
    } entry_t;

    logic        i_clk;
    logic        i_nrst;
    logic        i_req_valid;
    logic [5:0]  i_req_cmd;
    logic [31:0] i_req_arg;
    logic        o_req_ready;
    logic        o_resp_valid;
    logic [31:0] o_resp_data;
    logic        i_resp_ready;

    entry_t      tbl[$];
    logic [31:0] rng;
    int          cycles = 0;
    int          timeout_limit = 0;
    int          cur_test = 0;
    int          cur_errs = 0;
    int          failed_tests = 0;

    tb_clk_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (4)
    ) u_clk_gen (
        .o_clk  (i_clk),
        .o_nrst (i_nrst)
    );

    sdcard_card_top #(
        .POWERUP_DELAY (POWERUP_DELAY),
        .VHS           (VHS_P),
        .PCIE_1_2V     (PCIE_1_2V_P),
        .PCIE_AVAIL    (PCIE_AVAIL_P),
        .VDD_WINDOW    (VDD_WINDOW_P),
        .CID_WORD      (CID_WORD_P),
        .RCA           (RCA_P)
    ) UUT (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req_cmd    (i_req_cmd),
        .i_req_arg    (i_req_arg),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_data  (o_resp_data),
        .i_resp_ready (i_resp_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // R7 word: PCIe bits and voltage masked, check pattern echoed
    function automatic logic [31:0] if_cond_expect(input logic [31:0] arg);
        logic [31:0] w;
        w       = 32'h0;
        w[13]   = arg[13] & PCIE_1_2V_P;
        w[12]   = arg[12] & PCIE_AVAIL_P;
        w[11:8] = arg[11:8] & VHS_P;
        w[7:0]  = arg[7:0];
        return w;
    endfunction

    function automatic logic [31:0] ocr_expect(input logic busy, input logic [31:0] arg);
        return {busy, 7'd0, arg[23:0] & VDD_WINDOW_P};
    endfunction

    task automatic add_entry(input logic [5:0] cmd, input logic [31:0] arg, input int idle,
                             input bit has_resp, input logic [31:0] exp, input int phase);
        tbl.push_back('{cmd: cmd, arg: arg, idle: idle, has_resp: has_resp,
                        exp: exp, phase: phase});
    endtask

    task automatic note_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        $display("FAIL %s: expected 0x%08h, got 0x%08h", name, exp, got);
        cur_errs++;
    endtask

    task automatic note_problem(input string what);
        $display("ERROR: %s", what);
        cur_errs++;
    endtask

    task automatic build_table();
        logic [31:0] a;
        // Busy bit still set, card stays idle
        add_entry(CMD_APP_CMD, 32'h0, 0, 1'b0, 32'h0, PH_ANY);
        add_entry(CMD_SD_SEND_OP_COND, 32'h40ff_8000, 0, 1'b1,
                  ocr_expect(1'b0, 32'h40ff_8000), PH_EARLY);
        // CMD8 is only legal while idle
        rng = xorshift32(rng);
        a   = rng;
        add_entry(CMD_IF_COND, a, 1, 1'b1, if_cond_expect(a), PH_ANY);
        rng = xorshift32(rng);
        a   = rng;
        add_entry(CMD_IF_COND, a, 0, 1'b1, if_cond_expect(a), PH_ANY);
        add_entry(CMD_GO_IDLE, 32'h0, 2, 1'b1, 32'h0, PH_ANY);
        // Illegal in idle
        add_entry(CMD_SD_SEND_OP_COND, 32'h00ff_8000, 0, 1'b1, SD_RESP_ILLEGAL, PH_ANY);
        add_entry(CMD_ALL_SEND_CID, 32'h0, 1, 1'b1, SD_RESP_ILLEGAL, PH_ANY);
        add_entry(6'd5, 32'h1234_5678, 0, 1'b1, SD_RESP_ILLEGAL, PH_ANY);
        add_entry(6'd63, 32'h0, 3, 1'b1, SD_RESP_ILLEGAL, PH_ANY);
        // Busy released, card goes ready
        add_entry(CMD_APP_CMD, 32'h0, 3, 1'b0, 32'h0, PH_ANY);
        add_entry(CMD_SD_SEND_OP_COND, 32'h4030_0000, 0, 1'b1,
                  ocr_expect(1'b1, 32'h4030_0000), PH_LATE);
        add_entry(CMD_VOLT_SWITCH, 32'h0, 1, 1'b1, 32'h0, PH_ANY);
        add_entry(CMD_ALL_SEND_CID, 32'h0, 0, 1'b1, CID_WORD_P, PH_ANY);
        add_entry(CMD_SEND_RCA, 32'h0, 2, 1'b1, {RCA_P, 16'h0}, PH_ANY);
        add_entry(CMD_IF_COND, 32'h0000_01aa, 0, 1'b1, SD_RESP_ILLEGAL, PH_ANY);
        add_entry(CMD_GO_IDLE, 32'h0, 1, 1'b1, 32'h0, PH_ANY);
        // Empty voltage window, card goes inactive
        add_entry(CMD_APP_CMD, 32'h0, 0, 1'b0, 32'h0, PH_ANY);
        add_entry(CMD_SD_SEND_OP_COND, 32'hff00_0000, 0, 1'b1,
                  ocr_expect(1'b1, 32'hff00_0000), PH_LATE);
        add_entry(CMD_GO_IDLE, 32'h0, 2, 1'b1, SD_RESP_ILLEGAL, PH_ANY);
        add_entry(CMD_APP_CMD, 32'h0, 0, 1'b1, SD_RESP_ILLEGAL, PH_ANY);
        add_entry(CMD_IF_COND, 32'h0000_01aa, 1, 1'b1, SD_RESP_ILLEGAL, PH_ANY);
        add_entry(CMD_ALL_SEND_CID, 32'h0, 0, 1'b1, SD_RESP_ILLEGAL, PH_ANY);
    endtask

    // Starts and ends just after a falling edge
    task automatic run_entry(input entry_t e, input int idx);
        int          stall;
        int          s;
        logic [31:0] held;
        cur_errs = 0;
        repeat (e.idle) @(negedge i_clk);
        if (e.phase == PH_LATE) begin
            while (cycles < POWERUP_DELAY + PWR_MARGIN) @(negedge i_clk);
        end
        i_req_cmd   = e.cmd;
        i_req_arg   = e.arg;
        i_req_valid = 1'b1;
        while (!o_req_ready) @(negedge i_clk);
        if (e.phase == PH_EARLY) begin
            assert (cycles < POWERUP_DELAY - PWR_MARGIN)
            else note_problem("early ACMD41 was issued too close to the power-up point");
        end
        @(negedge i_clk);
        i_req_valid = 1'b0;
        if (!e.has_resp) begin
            while (!o_req_ready) begin
                assert (!o_resp_valid)
                else note_mismatch("o_resp_valid", 32'h0, {31'd0, o_resp_valid});
                @(negedge i_clk);
            end
            assert (!o_resp_valid)
            else note_mismatch("o_resp_valid", 32'h0, {31'd0, o_resp_valid});
        end else begin
            while (!o_resp_valid) begin
                assert (!o_req_ready)
                else note_mismatch("o_req_ready", 32'h0, {31'd0, o_req_ready});
                @(negedge i_clk);
            end
            assert (o_resp_data == e.exp)
            else note_mismatch("o_resp_data", e.exp, o_resp_data);
            held  = o_resp_data;
            rng   = xorshift32(rng);
            stall = int'(rng[1:0]);
            for (s = 0; s < stall; s++) begin
                @(negedge i_clk);
                assert (o_resp_valid)
                else note_mismatch("o_resp_valid", 32'h1, {31'd0, o_resp_valid});
                assert (o_resp_data == held)
                else note_mismatch("o_resp_data", held, o_resp_data);
                assert (!o_req_ready)
                else note_mismatch("o_req_ready", 32'h0, {31'd0, o_req_ready});
            end
            i_resp_ready = 1'b1;
            @(negedge i_clk);
            i_resp_ready = 1'b0;
            assert (!o_resp_valid)
            else note_mismatch("o_resp_valid", 32'h0, {31'd0, o_resp_valid});
        end
        if (cur_errs != 0) begin
            failed_tests++;
        end
        $display("test %0d cmd %0d arg 0x%08h: %s", idx, e.cmd, e.arg,
                 (cur_errs == 0) ? "pass" : "fail");
    endtask

    // Cycles since reset release, also the run limit
    always @(posedge i_clk) begin
        if (i_nrst) begin
            cycles <= cycles + 1;
        end
        assert (cycles < timeout_limit || timeout_limit == 0) else begin
            $display("ERROR: no response within limit, test %0d stopped at cycle %0d",
                     cur_test, cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        i_req_valid  = 1'b0;
        i_req_cmd    = 6'd0;
        i_req_arg    = 32'h0;
        i_resp_ready = 1'b0;
        rng          = SEED;
        build_table();
        timeout_limit = tbl.size() * (SD_DLY_LONG + MAX_IDLE + MAX_STALL + 8)
                        + POWERUP_DELAY;
        @(posedge i_nrst);
        @(negedge i_clk);
        foreach (tbl[i]) begin
            cur_test = i;
            run_entry(tbl[i], i);
        end
        $display("%0d tests run, %0d passed, %0d failed", tbl.size(),
                 tbl.size() - failed_tests, failed_tests);
        if (failed_tests == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/sdcard_proto_pkg.sv
rtl/sdcard_model_pkg.sv
rtl/sdcard_timers.sv
rtl/sdcard_resp_builder.sv
rtl/sdcard_cmd_fsm.sv
rtl/sdcard_card_top.sv
tests/tb_clk_gen.sv
tests/tb_sdcard_card.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SD card model testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing -f compile.f --top-module tb_sdcard_card -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
exit 1
